/* hdl/sd_clk_pkg.sv */
/*
 * SD clock package
 * Divider width and the strobe bundle that the SD clock generator
 * hands to the data path
 */

package sd_clk_pkg;

  // Default width of the clock divider value
  localparam int DivWidth = 8;

  // One clk_i pulse per SD clock edge
  typedef struct packed {
    // Cycle that ends with the SD clock rising
    logic en_p;
    // Cycle that ends with the SD clock falling
    logic en_n;
    // Divider is zero, SD clock is clk_i itself
    logic div_1;
  } sd_clk_en_t;

endpackage

/* hdl/sd_dat_pkg.sv */
/*
 * SD DAT write package
 * Block-write states, bus configuration and the status bundle
 * reported back to the host side
 */

package sd_dat_pkg;

  // Default width of the block size in bytes
  localparam int MaxBlockBitSize = 10;

  typedef enum logic [3:0] {
    READY,
    START_BIT,
    DAT,
    CRC,
    END_BIT,
    BUS_SWITCH,
    STATUS_START_BIT,
    STATUS,
    STATUS_END_BIT,
    BUSY,
    DONE
  } dat_tx_state_e;

  typedef struct packed {
    logic                       bus_width_is_4;
    logic [MaxBlockBitSize-1:0] block_size;  // bytes
  } sd_bus_cfg_t;

  typedef struct packed {
    logic waiting;
    logic done;
    logic crc_err;
    logic end_bit_err;
  } sd_dat_status_t;

endpackage

/* hdl/sd_clk_gen.sv */
/*
 * SD clock generator
 * Divides clk_i into the card clock and gives one-cycle strobes for
 * its rising and falling edges. A divider of zero passes clk_i through
 */

`timescale 1ns/1ps

module sd_clk_gen #(
  parameter int DivWidth = sd_clk_pkg::DivWidth
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [DivWidth-1:0]    clk_div_i,
  output logic                   sd_clk_o,
  output sd_clk_pkg::sd_clk_en_t clk_en_o
);
  import sd_clk_pkg::*;

  logic [DivWidth-1:0] count_q;
  logic                sd_clk_q;
  logic                div_1;
  logic                terminal;
  sd_clk_en_t          clk_en;

  assign div_1    = (clk_div_i == '0);
  // >= so a smaller divider written mid-count does not wrap
  assign terminal = (count_q >= clk_div_i);

  // Each SD clock half period is clk_div_i + 1 cycles of clk_i
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      count_q  <= '0;
      sd_clk_q <= 1'b0;
    end else if (div_1) begin
      count_q  <= '0;
      sd_clk_q <= 1'b0;
    end else if (terminal) begin
      count_q  <= '0;
      sd_clk_q <= ~sd_clk_q;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  // Strobe sits in the cycle whose closing edge flips the SD clock
  assign clk_en.en_p  = div_1 | (terminal & ~sd_clk_q);
  assign clk_en.en_n  = div_1 | (terminal & sd_clk_q);
  assign clk_en.div_1 = div_1;

  assign clk_en_o = clk_en;
  assign sd_clk_o = div_1 ? clk_i : sd_clk_q;

endmodule

/* hdl/crc16_write.sv */
/*
 * CRC16 for one DAT lane
 * CRC-CCITT (x^16+x^12+x^5+1, zero start) over the serial data,
 * then shifted out MSB first on request
 */

`timescale 1ns/1ps

module crc16_write (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic sd_clk_en_i,
  input  logic shift_out_crc16_i,
  input  logic dat_ser_i,
  output logic crc_ser_o
);

  logic [15:0] crc_q;
  logic [15:0] crc_d;
  logic        feedback;

  assign feedback = dat_ser_i ^ crc_q[15];

  always_comb begin
    if (shift_out_crc16_i) begin
      // Zeros fill in, register is clear after 16 shifts
      crc_d = {crc_q[14:0], 1'b0};
    end else begin
      crc_d = {crc_q[14:0], 1'b0} ^ (feedback ? 16'h1021 : 16'h0000);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      crc_q <= '0;
    end else if (sd_clk_en_i) begin
      crc_q <= crc_d;
    end
  end

  assign crc_ser_o = crc_q[15];

endmodule

/* hdl/dat_write.sv */
/*
 * SD block writer
 * Sends one data block with start bit, per-lane CRC16 and end bit,
 * then reads the CRC status token on DAT0 and waits out card busy
 */

`timescale 1ns/1ps

module dat_write #(
  parameter int MaxBlockBitSize = sd_dat_pkg::MaxBlockBitSize
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  sd_clk_pkg::sd_clk_en_t     clk_en_i,
  input  logic                       start_i,
  input  sd_dat_pkg::sd_bus_cfg_t    cfg_i,
  input  logic [31:0]                data_i,
  output logic                       next_word_o,
  input  logic                       dat0_i,
  output logic [3:0]                 dat_o,
  output logic                       dat_en_o,
  output sd_dat_pkg::sd_dat_status_t status_o
);
  import sd_dat_pkg::*;

  // Room for block_size * 8 + 16
  localparam int CounterWidth = MaxBlockBitSize + 4;

  // Drive enable and line values move together
  typedef struct packed {
    logic       en;
    logic [3:0] dat;
  } lane_t;

  localparam lane_t LaneIdle = '{en: 1'b0, dat: 4'b1111};

  dat_tx_state_e state_q, state_d;

  logic [CounterWidth-1:0]    counter_q, counter_d;
  logic [MaxBlockBitSize-1:0] block_size;
  logic [CounterWidth-1:0]    data_len;
  logic [CounterWidth-1:0]    last_dat;
  logic [CounterWidth-1:0]    last_crc;

  logic [31:0] buf_q, buf_d;

  // Status token from the card
  logic       tok_start_q, tok_start_d;
  logic       tok_end_q, tok_end_d;
  logic [2:0] token_q, token_d;

  lane_t      lane, lane_divn_q, lane_div1_q;
  logic       shift_out_crc;
  logic [3:0] crc;

  assign block_size = cfg_i.block_size[MaxBlockBitSize-1:0];
  assign data_len   = cfg_i.bus_width_is_4 ? CounterWidth'(block_size) << 1
                                           : CounterWidth'(block_size) << 3;
  assign last_dat   = data_len - CounterWidth'(1);
  assign last_crc   = data_len + CounterWidth'(15);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      READY:            if (start_i) state_d = START_BIT;
      START_BIT:        state_d = DAT;
      DAT:              if (counter_q == last_dat) state_d = CRC;
      CRC:              if (counter_q == last_crc) state_d = END_BIT;
      END_BIT:          state_d = BUS_SWITCH;
      BUS_SWITCH:       if (counter_q == CounterWidth'(1)) state_d = STATUS_START_BIT;
      STATUS_START_BIT: state_d = STATUS;
      STATUS:           if (counter_q == CounterWidth'(2)) state_d = STATUS_END_BIT;
      STATUS_END_BIT:   state_d = BUSY;
      BUSY:             if (dat0_i) state_d = DONE;
      DONE:             state_d = READY;
      default:          state_d = READY;
    endcase
  end

  // data_i holds word 0 when start is seen; a pulse marks a word taken
  always_comb begin
    lane          = LaneIdle;
    counter_d     = '0;
    buf_d         = buf_q;
    tok_start_d   = tok_start_q;
    tok_end_d     = tok_end_q;
    token_d       = token_q;
    next_word_o   = 1'b0;
    shift_out_crc = 1'b1;

    unique case (state_q)
      START_BIT: begin
        lane.en     = 1'b1;
        lane.dat    = cfg_i.bus_width_is_4 ? 4'b0000 : 4'b1110;
        buf_d       = data_i;
        tok_start_d = 1'b0;
        tok_end_d   = 1'b1;
        token_d     = '0;
      end
      DAT: begin
        counter_d     = counter_q + 1'b1;
        shift_out_crc = 1'b0;
        lane.en       = 1'b1;
        if (cfg_i.bus_width_is_4) begin
          // Two SD clocks per byte, high nibble first
          next_word_o = clk_en_i.en_p && (counter_q[2:0] == 3'd0);
          if (counter_q[2:0] == 3'd7) begin
            buf_d = data_i;
          end else if (counter_q[0]) begin
            buf_d = {8'h00, buf_q[31:8]};
          end
          lane.dat = counter_q[0] ? buf_q[3:0] : buf_q[7:4];
        end else begin
          // Eight SD clocks per byte on line 0
          next_word_o = clk_en_i.en_p && (counter_q[4:0] == 5'd0);
          if (counter_q[4:0] == 5'd31) begin
            buf_d = data_i;
          end else if (counter_q[2:0] == 3'd7) begin
            buf_d = {8'h00, buf_q[31:8]};
          end else begin
            buf_d[7:0] = {buf_q[6:0], 1'b0};
          end
          lane.dat = {3'b111, buf_q[7]};
        end
      end
      CRC: begin
        counter_d = counter_q + 1'b1;
        lane.en   = 1'b1;
        lane.dat  = cfg_i.bus_width_is_4 ? crc : {3'b111, crc[0]};
      end
      END_BIT: begin
        lane.en = 1'b1;
      end
      BUS_SWITCH: counter_d = counter_q + 1'b1;
      STATUS_START_BIT: tok_start_d = dat0_i;
      STATUS: begin
        counter_d = counter_q + 1'b1;
        token_d   = {token_q[1:0], dat0_i};
      end
      STATUS_END_BIT: tok_end_d = dat0_i;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= READY;
      counter_q   <= '0;
      tok_start_q <= 1'b0;
      tok_end_q   <= 1'b1;
      token_q     <= 3'b010;
    end else if (clk_en_i.en_p) begin
      state_q     <= state_d;
      counter_q   <= counter_d;
      tok_start_q <= tok_start_d;
      tok_end_q   <= tok_end_d;
      token_q     <= token_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (clk_en_i.en_p) begin
      buf_q <= buf_d;
    end
  end

  // Lines change half an SD clock after the state
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      lane_divn_q <= LaneIdle;
    end else if (clk_en_i.en_n) begin
      lane_divn_q <= lane;
    end
  end

  // Divide-by-one has no falling strobe, use the clk_i falling edge
  always_ff @(negedge clk_i) begin
    if (!rst_ni) begin
      lane_div1_q <= LaneIdle;
    end else begin
      lane_div1_q <= lane;
    end
  end

  assign dat_o    = clk_en_i.div_1 ? lane_div1_q.dat : lane_divn_q.dat;
  assign dat_en_o = clk_en_i.div_1 ? lane_div1_q.en : lane_divn_q.en;

  assign status_o.waiting     = (state_q == BUSY);
  assign status_o.done        = (state_q == DONE) && clk_en_i.en_p;
  assign status_o.crc_err     = (token_q != 3'b010);
  assign status_o.end_bit_err = tok_start_q | ~tok_end_q;

  for (genvar i = 0; i < 4; i++) begin : g_crc
    crc16_write i_crc16_write (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .sd_clk_en_i       (clk_en_i.en_p),
      .shift_out_crc16_i (shift_out_crc),
      .dat_ser_i         (lane.dat[i]),
      .crc_ser_o         (crc[i])
    );
  end

endmodule

/* hdl/sd_dat_tx_top.sv */
/*
 * SD DAT write path top level
 * SD clock generator feeding the block writer
 */

`timescale 1ns/1ps

module sd_dat_tx_top #(
  parameter int MaxBlockBitSize = sd_dat_pkg::MaxBlockBitSize,
  parameter int DivWidth        = sd_clk_pkg::DivWidth
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [DivWidth-1:0]        clk_div_i,
  input  logic                       start_i,
  input  sd_dat_pkg::sd_bus_cfg_t    cfg_i,
  input  logic [31:0]                data_i,
  output logic                       next_word_o,
  input  logic                       dat0_i,
  output logic [3:0]                 dat_o,
  output logic                       dat_en_o,
  output logic                       sd_clk_o,
  output sd_dat_pkg::sd_dat_status_t status_o
);
  import sd_clk_pkg::*;

  sd_clk_en_t clk_en;

  sd_clk_gen #(
    .DivWidth (DivWidth)
  ) i_clk_gen (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clk_div_i (clk_div_i),
    .sd_clk_o  (sd_clk_o),
    .clk_en_o  (clk_en)
  );

  dat_write #(
    .MaxBlockBitSize (MaxBlockBitSize)
  ) i_dat_write (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clk_en_i    (clk_en),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .data_i      (data_i),
    .next_word_o (next_word_o),
    .dat0_i      (dat0_i),
    .dat_o       (dat_o),
    .dat_en_o    (dat_en_o),
    .status_o    (status_o)
  );

endmodule

/* verif/sd_dat_tx_asserts.sv */
/*
 * Protocol assertions for the SD DAT write path
 * Bound into the top level
 */

`timescale 1ns/1ps

module sd_dat_tx_asserts (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       next_word_o,
  input logic [3:0]                 dat_o,
  input logic                       dat_en_o,
  input sd_dat_pkg::sd_dat_status_t status_o
);

  // Done is a single clk_i pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni) status_o.done |=> !status_o.done)
    else $error("done lasted more than one cycle");

  assert property (@(posedge clk_i) disable iff (!rst_ni) next_word_o |-> dat_en_o)
    else $error("word request while the lines are not driven");

  // Card owns DAT0 while busy
  assert property (@(posedge clk_i) disable iff (!rst_ni) status_o.waiting |-> !dat_en_o)
    else $error("lines driven during busy");

  assert property (@(posedge clk_i) $rose(rst_ni) |-> (!dat_en_o && !next_word_o &&
                   !status_o.done && !status_o.waiting && dat_o == 4'hf))
    else $error("outputs not idle after reset");

endmodule

bind sd_dat_tx_top sd_dat_tx_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .next_word_o (next_word_o),
  .dat_o       (dat_o),
  .dat_en_o    (dat_en_o),
  .status_o    (status_o)
);

/* verif/tb_sd_dat_tx.sv */
/*
 * Testbench for the SD DAT write path
 * Drives block writes, models the card on DAT0 and checks the line
 * stream, per-lane CRC16, status token handling and busy
 */

`timescale 1ns/1ps

module tb_sd_dat_tx;
  import sd_dat_pkg::*;

  logic                 clk_i = 1'b0;
  logic                 rst_ni = 1'b0;
  logic [7:0]           clk_div_i = 8'd2;
  logic                 start_i = 1'b0;
  sd_bus_cfg_t          cfg_i = '0;
  logic [31:0]          data_i = '0;
  logic                 dat0_i = 1'b1;
  logic                 next_word_o;
  logic [3:0]           dat_o;
  logic                 dat_en_o;
  logic                 sd_clk_o;
  sd_dat_status_t       status_o;

  logic [31:0] words [4];
  logic [31:0] lfsr_q = 32'hbbd04569;
  logic [3:0]  exp_q [$];
  logic [3:0]  cap_q [$];

  sd_dat_tx_top #(.MaxBlockBitSize(5), .DivWidth(8)) dut0 (.*);

  always #5 clk_i = ~clk_i;

  task automatic die(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input string what,
                       input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else
      die($sformatf("[FAIL] %s %s: expected %0h actual %0h", name, what, exp, act));
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic lfsr_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) lfsr_q = lfsr_q ^ 32'ha3000000;
    return out;
  endfunction

  function automatic logic [31:0] lfsr_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) w = {w[30:0], lfsr_bit()};
    return w;
  endfunction

  // Remainder of the lane's data bits times x^16 over x^16+x^12+x^5+1
  function automatic logic [15:0] lane_crc(input int lane, input int nbits);
    logic [16:0] rem;
    logic [3:0]  v;
    rem = '0;
    for (int i = 0; i < nbits + 16; i++) begin
      v   = (i < nbits) ? exp_q[i + 1] : 4'h0;
      rem = {rem[15:0], v[lane]};
      if (rem[16]) rem = rem ^ 17'h11021;
    end
    return rem[15:0];
  endfunction

  // Line values per SD clock: start, data, CRC16 of each lane, end bit
  task automatic build_expected(input logic w4, input int bsize);
    logic [15:0] crc [4];
    logic [7:0]  byt;
    logic [3:0]  v;
    exp_q.delete();
    exp_q.push_back(w4 ? 4'h0 : 4'he);
    for (int i = 0; i < bsize; i++) begin
      byt = words[i / 4][8 * (i % 4) +: 8];
      if (w4) begin
        exp_q.push_back(byt[7:4]);
        exp_q.push_back(byt[3:0]);
      end else begin
        for (int b = 7; b >= 0; b--) begin
          exp_q.push_back({3'b111, byt[b]});
        end
      end
    end
    for (int l = 0; l < 4; l++) crc[l] = lane_crc(l, exp_q.size() - 1);
    for (int k = 15; k >= 0; k--) begin
      v = w4 ? {crc[3][k], crc[2][k], crc[1][k], crc[0][k]} : {3'b111, crc[0][k]};
      exp_q.push_back(v);
    end
    exp_q.push_back(4'hf);
  endtask

  // Card side: capture the block, then answer token and busy on DAT0
  task automatic card_model(input string name, input logic ts, input logic [2:0] tok,
                            input logic te, input int bl);
    int  guard;
    logic block_end;
    guard     = 0;
    block_end = 1'b0;
    cap_q.delete();
    while (!block_end) begin
      @(posedge sd_clk_o);
      guard++;
      if (guard > 2000) die("Timeout: card model never saw the end of the data block");
      if (dat_en_o) cap_q.push_back(dat_o);
      else if (cap_q.size() > 0) block_end = 1'b1;
    end
    for (int k = 1; k <= 7 + bl; k++) begin
      if (k > 1) @(posedge sd_clk_o);
      check(name, "dat_en after block", 32'd0, 32'(dat_en_o));
      if (k == 2) dat0_i <= ts;
      else if (k >= 3 && k <= 5) dat0_i <= tok[5 - k];
      else if (k == 6) dat0_i <= te;
      else if (k >= 7 && k < 7 + bl) dat0_i <= 1'b0;
      else dat0_i <= 1'b1;
    end
  endtask

  task automatic host_side(input string name, input int bsize, input int bl, input int period,
                           input logic exp_crc, input logic exp_ebe);
    int   guard;
    int   idx;
    int   wait_cycles;
    logic seen_done;
    guard       = 0;
    idx         = 0;
    wait_cycles = 0;
    seen_done   = 1'b0;
    while (!seen_done) begin
      @(posedge clk_i);
      guard++;
      if (guard > 20000) die("Timeout: done never came from the block writer");
      if (start_i && dat_en_o) start_i <= 1'b0;
      if (next_word_o) begin
        idx++;
        if (idx < 4) data_i <= words[idx];
      end
      if (status_o.waiting) wait_cycles++;
      if (status_o.done) begin
        seen_done = 1'b1;
        check(name, "dat0 at done", 32'd1, 32'(dat0_i));
        check(name, "crc_err", 32'(exp_crc), 32'(status_o.crc_err));
        check(name, "end_bit_err", 32'(exp_ebe), 32'(status_o.end_bit_err));
      end
    end
    check(name, "word requests", 32'(bsize / 4), 32'(idx));
    check(name, "waiting cycles", 32'((bl + 1) * period), 32'(wait_cycles));
  endtask

  task automatic run_write(input string name, input int div, input logic w4, input int bsize,
                           input logic ts, input logic [2:0] tok, input logic te, input int bl,
                           input logic exp_crc, input logic exp_ebe);
    int period;
    period = (div == 0) ? 1 : 2 * (div + 1);
    for (int i = 0; i < 4; i++) words[i] = lfsr_word();
    @(posedge clk_i);
    clk_div_i <= 8'(div);
    cfg_i     <= '{bus_width_is_4: w4, block_size: 10'(bsize)};
    data_i    <= words[0];
    repeat (8) @(posedge clk_i);
    start_i <= 1'b1;
    build_expected(w4, bsize);
    fork
      card_model(name, ts, tok, te, bl);
      host_side(name, bsize, bl, period, exp_crc, exp_ebe);
    join
    check(name, "bit count", 32'(exp_q.size()), 32'(cap_q.size()));
    for (int i = 0; i < exp_q.size(); i++) begin
      check(name, $sformatf("lines at bit %0d", i), 32'(exp_q[i]), 32'(cap_q[i]));
    end
  endtask

  initial begin
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    run_write("wide_div2", 2, 1'b1, 16, 1'b0, 3'b010, 1'b1, 3, 1'b0, 1'b0);
    run_write("narrow_div1", 0, 1'b0, 8, 1'b0, 3'b010, 1'b1, 2, 1'b0, 1'b0);
    run_write("bad_token", 1, 1'b1, 4, 1'b0, 3'b101, 1'b1, 1, 1'b1, 1'b0);
    run_write("bad_start", 0, 1'b0, 4, 1'b1, 3'b010, 1'b1, 4, 1'b0, 1'b1);
    run_write("bad_end", 3, 1'b1, 8, 1'b0, 3'b010, 1'b0, 6, 1'b0, 1'b1);
    repeat (10) @(posedge clk_i);
    $display(">>> PASS");
    $finish;
  end

endmodule

/* project.f */
hdl/sd_clk_pkg.sv
hdl/sd_dat_pkg.sv
hdl/sd_clk_gen.sv
hdl/crc16_write.sv
hdl/dat_write.sv
hdl/sd_dat_tx_top.sv
verif/sd_dat_tx_asserts.sv
verif/tb_sd_dat_tx.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SD DAT write testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sd_dat_tx \
  -f project.f -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log

! grep -q ">>> FAIL" sim.log && grep -q ">>> PASS" sim.log && exit 0 \
  || { echo "Simulation failed"; exit 1; }
